/* hdl/bus_sequencer.sv */
`timescale 1ns/10ps

module bus_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::bus_op_e bus_op,
    input  cpu_pkg::addr_t   addr,
    input  cpu_pkg::byte_t   wdata,
    input  cpu_pkg::byte_t   din,
    output cpu_pkg::t_state_e ct,
    output logic             phi,
    output logic             rd,
    output logic             wr,
    output cpu_pkg::addr_t   a,
    output cpu_pkg::byte_t   dout,
    output cpu_pkg::byte_t   fetched
);
    import cpu_pkg::*;

    logic is_read;

    assign is_read = (bus_op == FETCH) || (bus_op == READ);

    // Free running T-state counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ct <= T0;
        else
            ct <= t_state_e'(ct + 1'b1);
    end

    ////////////////////////////////////////
    // Bus drive, one step per T-state
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a    <= '0;
            rd   <= 1'b0;
            wr   <= 1'b0;
            phi  <= 1'b0;
            dout <= '0;
        end else begin
            case (ct)
                T0: begin                  // Entering T1
                    if (bus_op != IDLE)
                        a <= addr;         // Idle cycles keep the old address
                    rd  <= is_read;
                    phi <= 1'b1;
                end
                T2: begin                  // Entering T3
                    rd  <= 1'b0;
                    phi <= 1'b0;
                    if (bus_op == WRITE) begin
                        wr   <= 1'b1;
                        dout <= wdata;
                    end
                end
                T3: begin                  // Back to T0
                    wr   <= 1'b0;
                    dout <= '0;
                end
                default: ;
            endcase
        end
    end

    // Read data capture
    always_ff @(posedge clk) begin
        if (ct == T2 && is_read)
            fetched <= din;
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr));
    a_wr_in_t3:   assert property (@(posedge clk) disable iff (rst) wr |-> ct == T3);

endmodule

/* hdl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Bus and machine cycle geometry
////////////////////////////////////////

`define CPU_ADDR_W    16
`define CPU_DATA_W    8
`define CPU_T_STATES  4     // Clocks per machine cycle

////////////////////////////////////////
// Interrupts
////////////////////////////////////////

`define CPU_INT_N     5
`define CPU_INT_BASE  'h40  // Vector of source 0
`define CPU_INT_STEP  8

////////////////////////////////////////
// Supported opcodes
////////////////////////////////////////

`define CPU_OP_NOP      8'h00
`define CPU_OP_STOP     8'h10
`define CPU_OP_LD_A_D8  8'h3E
`define CPU_OP_HALT     8'h76
`define CPU_OP_JP       8'hC3
`define CPU_OP_ADD_D8   8'hC6
`define CPU_OP_SUB_D8   8'hD6
`define CPU_OP_LD_A16_A 8'hEA
`define CPU_OP_DI       8'hF3
`define CPU_OP_EI       8'hFB

`endif

/* hdl/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_W-1:0] addr_t;     // Bus address or PC
    typedef logic [`CPU_DATA_W-1:0] byte_t;
    typedef logic [`CPU_INT_N-1:0]  int_vec_t;  // Bit 0 wins

    typedef logic [2:0] m_cycle_t;              // Machine cycle inside an instruction

    typedef enum logic [$clog2(`CPU_T_STATES)-1:0] {
        T0,
        T1,
        T2,
        T3
    } t_state_e;

    // Bus operation of one machine cycle
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        READ,
        WRITE
    } bus_op_e;

    typedef enum logic {
        PC,
        IMM
    } ab_src_e;

    typedef enum logic [1:0] {
        RUN,
        HALTED,
        STOPPED,
        FAULTED
    } dec_state_e;

endpackage

/* hdl/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
    input  logic              clk,
    input  logic              rst,
    output logic              phi,
    output logic              rd,
    output logic              wr,
    output cpu_pkg::t_state_e ct,
    output cpu_pkg::addr_t    a,
    output cpu_pkg::byte_t    dout,
    input  cpu_pkg::byte_t    din,
    input  cpu_pkg::int_vec_t int_en,
    input  cpu_pkg::int_vec_t int_flags_in,
    output cpu_pkg::int_vec_t int_flags_out,
    input  cpu_pkg::byte_t    key_in,
    output logic              done,
    output logic              fault
);
    import cpu_pkg::*;

    bus_op_e bus_op;
    ab_src_e ab_src;
    addr_t   addr;
    addr_t   vector;
    byte_t   acc;
    byte_t   fetched;
    logic    acc_load, acc_add, acc_sub;
    logic    imm_lo_load, imm_hi_load;
    logic    pc_inc, pc_jump;
    logic    dispatch, ime_set, ime_clr;
    logic    int_pending, wake;

    bus_sequencer u_bus (
        .clk(clk), .rst(rst), .bus_op(bus_op), .addr(addr), .wdata(acc), .din(din),
        .ct(ct), .phi(phi), .rd(rd), .wr(wr), .a(a), .dout(dout), .fetched(fetched)
    );

    decoder u_dec (
        .clk(clk), .rst(rst), .ct(ct), .fetched(fetched),
        .int_pending(int_pending), .wake(wake), .bus_op(bus_op), .ab_src(ab_src),
        .acc_load(acc_load), .acc_add(acc_add), .acc_sub(acc_sub),
        .imm_lo_load(imm_lo_load), .imm_hi_load(imm_hi_load),
        .pc_inc(pc_inc), .pc_jump(pc_jump), .dispatch(dispatch),
        .ime_set(ime_set), .ime_clr(ime_clr), .done(done), .fault(fault)
    );

    execute u_exe (
        .clk(clk), .rst(rst), .ct(ct), .fetched(fetched), .ab_src(ab_src), .vector(vector),
        .acc_load(acc_load), .acc_add(acc_add), .acc_sub(acc_sub),
        .imm_lo_load(imm_lo_load), .imm_hi_load(imm_hi_load),
        .pc_inc(pc_inc), .pc_jump(pc_jump), .dispatch(dispatch),
        .addr(addr), .acc(acc)
    );

    interrupt_unit u_int (
        .clk(clk), .rst(rst), .ct(ct), .int_en(int_en), .int_flags_in(int_flags_in),
        .key_in(key_in), .ime_set(ime_set), .ime_clr(ime_clr), .dispatch(dispatch),
        .int_flags_out(int_flags_out), .vector(vector),
        .int_pending(int_pending), .wake(wake)
    );

endmodule

/* hdl/decoder.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module decoder (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::t_state_e ct,
    input  cpu_pkg::byte_t    fetched,
    input  logic              int_pending,
    input  logic              wake,
    output cpu_pkg::bus_op_e  bus_op,
    output cpu_pkg::ab_src_e  ab_src,
    output logic              acc_load,
    output logic              acc_add,
    output logic              acc_sub,
    output logic              imm_lo_load,
    output logic              imm_hi_load,
    output logic              pc_inc,
    output logic              pc_jump,
    output logic              dispatch,
    output logic              ime_set,
    output logic              ime_clr,
    output logic              done,
    output logic              fault
);
    import cpu_pkg::*;

    dec_state_e state, nxt_state;
    m_cycle_t   m_cycle, nxt_mc;
    bus_op_e    nxt_op;
    ab_src_e    nxt_src;
    byte_t      opcode;
    byte_t      cur_op;

    // Opcode is still on the bus side during the fetch cycle
    assign cur_op = (m_cycle == 3'd0) ? fetched : opcode;
    assign fault  = (state == FAULTED);

    ////////////////////////////////////////
    // Per machine cycle control
    ////////////////////////////////////////

    always_comb begin
        acc_load    = 1'b0;
        acc_add     = 1'b0;
        acc_sub     = 1'b0;
        imm_lo_load = 1'b0;
        imm_hi_load = 1'b0;
        pc_inc      = 1'b0;
        pc_jump     = 1'b0;
        dispatch    = 1'b0;
        ime_set     = 1'b0;
        ime_clr     = 1'b0;
        nxt_state   = state;
        nxt_mc      = m_cycle;
        nxt_op      = bus_op;
        nxt_src     = ab_src;
        if (ct == T3) begin
            case (state)
                RUN: begin
                    nxt_mc  = 3'd0;        // Single cycle unless told otherwise
                    nxt_op  = FETCH;
                    nxt_src = PC;
                    if (m_cycle == 3'd0 && int_pending) begin
                        dispatch = 1'b1;   // Opcode byte is dropped
                    end else begin
                        case (cur_op)
                            `CPU_OP_NOP: pc_inc = 1'b1;
                            `CPU_OP_DI: begin
                                pc_inc  = 1'b1;
                                ime_clr = 1'b1;
                            end
                            `CPU_OP_EI: begin
                                pc_inc  = 1'b1;
                                ime_set = 1'b1;
                            end
                            `CPU_OP_HALT, `CPU_OP_STOP: begin
                                pc_inc    = 1'b1;
                                nxt_op    = IDLE;
                                nxt_state = (cur_op == `CPU_OP_HALT) ? HALTED : STOPPED;
                            end
                            `CPU_OP_LD_A_D8, `CPU_OP_ADD_D8, `CPU_OP_SUB_D8: begin
                                pc_inc = 1'b1;
                                if (m_cycle == 3'd0) begin
                                    nxt_mc = 3'd1;
                                    nxt_op = READ;
                                end else begin
                                    acc_load = (cur_op == `CPU_OP_LD_A_D8);
                                    acc_add  = (cur_op == `CPU_OP_ADD_D8);
                                    acc_sub  = (cur_op == `CPU_OP_SUB_D8);
                                end
                            end
                            `CPU_OP_JP, `CPU_OP_LD_A16_A: begin
                                case (m_cycle)
                                    3'd0: begin
                                        pc_inc = 1'b1;
                                        nxt_mc = 3'd1;
                                        nxt_op = READ;
                                    end
                                    3'd1: begin       // Low address byte
                                        pc_inc      = 1'b1;
                                        imm_lo_load = 1'b1;
                                        nxt_mc      = 3'd2;
                                        nxt_op      = READ;
                                    end
                                    3'd2: begin       // High address byte
                                        imm_hi_load = 1'b1;
                                        if (cur_op == `CPU_OP_JP) begin
                                            pc_jump = 1'b1;
                                        end else begin
                                            pc_inc  = 1'b1;
                                            nxt_mc  = 3'd3;
                                            nxt_op  = WRITE;
                                            nxt_src = IMM;
                                        end
                                    end
                                    default: ;        // Store cycle, nothing left
                                endcase
                            end
                            default: begin
                                nxt_op    = IDLE;
                                nxt_state = FAULTED;
                            end
                        endcase
                    end
                end
                HALTED, STOPPED: begin
                    if (wake) begin
                        nxt_state = RUN;
                        nxt_op    = FETCH;
                        nxt_src   = PC;
                    end
                end
                default: ;                 // Faulted, stuck until reset
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RUN;
            m_cycle <= '0;
            bus_op  <= FETCH;
            ab_src  <= PC;
            done    <= 1'b0;
        end else begin
            state   <= nxt_state;
            m_cycle <= nxt_mc;
            bus_op  <= nxt_op;
            ab_src  <= nxt_src;
            done    <= (state != RUN);
        end
    end

    always_ff @(posedge clk) begin
        if (ct == T3 && state == RUN && m_cycle == 3'd0)
            opcode <= fetched;
    end

    a_pc_one_src: assert property (@(posedge clk) disable iff (rst) !(pc_inc && pc_jump));

endmodule

/* hdl/execute.sv */
`timescale 1ns/10ps

module execute (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::t_state_e ct,
    input  cpu_pkg::byte_t    fetched,
    input  cpu_pkg::ab_src_e  ab_src,
    input  cpu_pkg::addr_t    vector,
    input  logic              acc_load,
    input  logic              acc_add,
    input  logic              acc_sub,
    input  logic              imm_lo_load,
    input  logic              imm_hi_load,
    input  logic              pc_inc,
    input  logic              pc_jump,
    input  logic              dispatch,
    output cpu_pkg::addr_t    addr,
    output cpu_pkg::byte_t    acc
);
    import cpu_pkg::*;

    addr_t pc;
    addr_t imm;
    addr_t jump_target;
    byte_t alu_res;
    logic  any_strobe;

    // JP takes its high byte in the same clock that it jumps
    assign jump_target = {fetched, imm[7:0]};

    assign alu_res = acc_sub ? acc - fetched : acc + fetched;   // Wraps at 256

    assign addr = (ab_src == IMM) ? imm : pc;

    assign any_strobe = acc_load | acc_add | acc_sub | imm_lo_load | imm_hi_load |
                        pc_inc | pc_jump | dispatch;

    ////////////////////////////////////////
    // Architectural registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= fetched;
        end else if (acc_add || acc_sub) begin
            acc <= alu_res;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pc <= '0;
        else if (dispatch)
            pc <= vector;
        else if (pc_jump)
            pc <= jump_target;
        else if (pc_inc)
            pc <= pc + 1'b1;   // Dedicated incrementer
    end

    // Operand address bytes
    always_ff @(posedge clk) begin
        if (imm_lo_load)
            imm[7:0] <= fetched;
        if (imm_hi_load)
            imm[15:8] <= fetched;
    end

    // Decoder only acts at the end of a machine cycle
    a_strobe_t3: assert property (@(posedge clk) disable iff (rst) any_strobe |-> ct == T3);

endmodule

/* hdl/interrupt_unit.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module interrupt_unit (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::t_state_e ct,
    input  cpu_pkg::int_vec_t int_en,
    input  cpu_pkg::int_vec_t int_flags_in,
    input  cpu_pkg::byte_t    key_in,
    input  logic              ime_set,
    input  logic              ime_clr,
    input  logic              dispatch,
    output cpu_pkg::int_vec_t int_flags_out,
    output cpu_pkg::addr_t    vector,
    output logic              int_pending,
    output logic              wake
);
    import cpu_pkg::*;

    logic     ime;         // Master enable
    int_vec_t masked;
    logic [2:0] sel_idx;

    assign masked      = int_flags_in & int_en & {`CPU_INT_N{ime}};
    assign int_pending = |masked;

    // Lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `CPU_INT_N - 1; i >= 0; i--) begin
            if (masked[i])
                sel_idx = 3'(i);
        end
    end

    assign vector = addr_t'(`CPU_INT_BASE + `CPU_INT_STEP * sel_idx);

    // Acknowledge only in the dispatch clock
    assign int_flags_out = dispatch ? (int_flags_in & ~(int_vec_t'(1) << sel_idx))
                                    : int_flags_in;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ime <= 1'b0;
        else if (dispatch || ime_clr)
            ime <= 1'b0;
        else if (ime_set)
            ime <= 1'b1;
    end

    // Wake ignores the master enable, a key press also counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wake <= 1'b0;
        else if (ct == T2)
            wake <= (|(int_flags_in & int_en)) || (key_in != '0);
    end

    a_dispatch_pending: assert property (@(posedge clk) disable iff (rst)
        dispatch |-> int_pending);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* tests/tb_cpu.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int LIMIT = 2000;   // About 240 clocks of program

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      phi, rd, wr, done, fault;
    t_state_e  ct;
    addr_t     a;
    byte_t     dout, din;
    int_vec_t  int_en = 5'b01011;
    int_vec_t  int_flags_in = '0;
    int_vec_t  int_flags_out;
    int_vec_t  irq_set = '0;
    int_vec_t  irq_clr = '0;
    byte_t     key_in = '0;
    int        errors = 0;
    int        cycles = 0;
    int        seed = 37989;

    // Reference model state
    byte_t     img [0:255];
    addr_t     m_pc, m_waddr;
    byte_t     m_acc, m_op, m_lo;
    logic [1:0] ops_left;
    logic [1:0] t_count;
    logic      m_ime, m_halted, m_stopped, m_fault, woke, rd_seen;
    int        n_dispatch, n_sleeps;
    int_vec_t  masked;
    logic      m_dispatch;

    cpu_top u_dut (
        .clk(clk), .rst(rst), .phi(phi), .rd(rd), .wr(wr), .ct(ct), .a(a), .dout(dout),
        .din(din), .int_en(int_en), .int_flags_in(int_flags_in),
        .int_flags_out(int_flags_out), .key_in(key_in), .done(done), .fault(fault)
    );

    tb_memory u_mem (.clk(clk), .rd(rd), .wr(wr), .a(a), .dout(dout), .din(din));

    always #50 clk = ~clk;

    // Flags are acknowledged by the CPU and requested by the stimulus
    always @(posedge clk) begin
        int_flags_in <= (int_flags_out | irq_set) & ~irq_clr;
    end

    function automatic addr_t lowest_vector(int_vec_t m);
        addr_t v;
        logic  found;
        v     = '0;
        found = 1'b0;
        for (int i = 0; i < `CPU_INT_N; i++) begin
            if (m[i] && !found) begin
                v     = addr_t'(`CPU_INT_BASE + `CPU_INT_STEP * i);
                found = 1'b1;
            end
        end
        return v;
    endfunction

    assign masked     = int_flags_in & int_en;
    assign m_dispatch = ct == T3 && rd_seen && ops_left == 0 && m_ime && masked != '0;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Expected T-state, free running from reset
    always @(posedge clk or posedge rst) begin
        if (rst)
            t_count <= '0;
        else
            t_count <= t_count + 1'b1;
    end

    always @(posedge clk or posedge rst) begin
        byte_t b;
        if (rst) begin
            m_pc       <= '0;
            m_acc      <= '0;
            m_op       <= '0;
            m_lo       <= '0;
            m_waddr    <= '0;
            ops_left   <= '0;
            m_ime      <= 1'b0;
            m_halted   <= 1'b0;
            m_stopped  <= 1'b0;
            m_fault    <= 1'b0;
            woke       <= 1'b0;
            rd_seen    <= 1'b0;
            n_dispatch <= 0;
            n_sleeps   <= 0;
        end else begin
            if (rd)
                rd_seen <= 1'b1;
            if (m_halted && (masked != '0 || (m_stopped && key_in != '0)))
                woke <= 1'b1;
            if (ct == T1 && rd && m_halted) begin   // Fetch after wake
                m_halted  <= 1'b0;
                m_stopped <= 1'b0;
                woke      <= 1'b0;
            end
            if (ct == T3) begin
                rd_seen <= 1'b0;
                b = img[m_pc[7:0]];
                if (rd_seen && ops_left == 0) begin
                    if (m_dispatch) begin
                        m_pc       <= lowest_vector(masked);
                        m_ime      <= 1'b0;
                        n_dispatch <= n_dispatch + 1;
                    end else begin
                        m_op <= b;
                        m_pc <= m_pc + 1'b1;
                        case (b)
                            `CPU_OP_NOP: ;
                            `CPU_OP_LD_A_D8, `CPU_OP_ADD_D8, `CPU_OP_SUB_D8: ops_left <= 2'd1;
                            `CPU_OP_JP, `CPU_OP_LD_A16_A: ops_left <= 2'd2;
                            `CPU_OP_EI: m_ime <= 1'b1;
                            `CPU_OP_DI: m_ime <= 1'b0;
                            `CPU_OP_HALT, `CPU_OP_STOP: begin
                                m_halted  <= 1'b1;
                                m_stopped <= (b == `CPU_OP_STOP);
                                n_sleeps  <= n_sleeps + 1;
                            end
                            default: m_fault <= 1'b1;
                        endcase
                    end
                end else if (rd_seen) begin                // Operand byte
                    ops_left <= ops_left - 1'b1;
                    m_pc     <= m_pc + 1'b1;
                    case (m_op)
                        `CPU_OP_LD_A_D8: m_acc <= b;
                        `CPU_OP_ADD_D8:  m_acc <= m_acc + b;
                        `CPU_OP_SUB_D8:  m_acc <= m_acc - b;
                        default: begin
                            if (ops_left == 2'd2)
                                m_lo <= b;
                            else if (m_op == `CPU_OP_JP)
                                m_pc <= {b, m_lo};
                            else
                                m_waddr <= {b, m_lo};
                        end
                    endcase
                end
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    c_ct: assert property (@(posedge clk) disable iff (rst) ct == t_count)
        else begin
            $display("ERROR: ct = %h, expected %h", ct, t_count);
            errors++;
        end
    c_phi: assert property (@(posedge clk) disable iff (rst) phi == (ct inside {T1, T2}))
        else begin
            $display("ERROR: phi = %h in ct = %h", phi, ct);
            errors++;
        end
    c_rd_phase: assert property (@(posedge clk) disable iff (rst) rd |-> ct inside {T1, T2})
        else begin
            $display("ERROR: rd = %h outside T1/T2, ct = %h", rd, ct);
            errors++;
        end
    c_wr_phase: assert property (@(posedge clk) disable iff (rst) wr |-> ct == T3)
        else begin
            $display("ERROR: wr = %h outside T3, ct = %h", wr, ct);
            errors++;
        end
    c_dout_idle: assert property (@(posedge clk) disable iff (rst) !wr |-> dout == '0)
        else begin
            $display("ERROR: dout = %h while wr is low", dout);
            errors++;
        end
    c_a_stable: assert property (@(posedge clk) disable iff (rst)
        ct inside {T2, T3} |-> $stable(a))
        else begin
            $display("ERROR: a = %h changed inside a machine cycle", a);
            errors++;
        end
    c_read_addr: assert property (@(posedge clk) disable iff (rst) (ct == T1 && rd) |-> a == m_pc)
        else begin
            $display("ERROR: a = %h, expected %h", a, m_pc);
            errors++;
        end
    c_write: assert property (@(posedge clk) disable iff (rst)
        wr |-> (a == m_waddr && dout == m_acc))
        else begin
            $display("ERROR: a/dout = %h/%h, expected %h/%h", a, dout, m_waddr, m_acc);
            errors++;
        end
    c_flags: assert property (@(posedge clk) disable iff (rst)
        int_flags_out == (m_dispatch ? int_flags_in & ~(masked & (~masked + 1'b1))
                                     : int_flags_in))
        else begin
            $display("ERROR: int_flags_out = %h, int_flags_in = %h", int_flags_out, int_flags_in);
            errors++;
        end
    c_sleep_rd: assert property (@(posedge clk) disable iff (rst) rd |-> (!m_halted || woke))
        else begin
            $display("Bus read while halted or stopped without a wake source");
            errors++;
        end
    c_done: assert property (@(posedge clk) disable iff (rst)
        ct == T2 |-> done == (m_halted || m_fault))
        else begin
            $display("ERROR: done = %h, expected %h", done, m_halted || m_fault);
            errors++;
        end
    c_fault: assert property (@(posedge clk) disable iff (rst)
        ct == T2 |-> fault == m_fault)
        else begin
            $display("ERROR: fault = %h, expected %h", fault, m_fault);
            errors++;
        end
    c_dead: assert property (@(posedge clk) disable iff (rst) m_fault |-> !(rd || wr))
        else begin
            $display("Bus activity after the fault");
            errors++;
        end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic put(input int addr, input byte_t value);
        img[addr]        = value;
        u_mem.mem[addr] = value;
    endtask

    task automatic wait_t0;
        @(posedge clk);
        while (ct != T0)
            @(posedge clk);
    endtask

    task automatic pulse_flags(input int_vec_t bits);
        wait_t0();
        irq_set <= bits;
        @(posedge clk);
        irq_set <= '0;
        irq_clr <= bits;
        @(posedge clk);
        irq_clr <= '0;
    endtask

    task automatic press_key(input byte_t value);
        wait_t0();
        key_in <= value;
        repeat (2) @(posedge clk);
        key_in <= '0;
    endtask

    initial begin
        @(posedge clk);
        for (int i = 0; i < 256; i++)
            put(i, `CPU_OP_NOP);
        put(8'h00, `CPU_OP_LD_A_D8);
        put(8'h01, byte_t'($random(seed)));
        put(8'h02, `CPU_OP_ADD_D8);
        put(8'h03, byte_t'($random(seed)));
        put(8'h04, `CPU_OP_SUB_D8);
        put(8'h05, byte_t'($random(seed)));
        put(8'h06, `CPU_OP_LD_A16_A);
        put(8'h07, 8'h00);
        put(8'h08, 8'hC0);
        put(8'h09, `CPU_OP_EI);
        put(8'h4B, `CPU_OP_HALT);     // Handler at vector 1
        put(8'h4D, `CPU_OP_STOP);
        put(8'h4F, `CPU_OP_JP);
        put(8'h50, 8'h80);
        put(8'h51, 8'h00);
        put(8'h80, 8'hD3);            // Undefined opcode
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        wait (m_ime);
        @(posedge clk);
        irq_set <= 5'b01010;
        @(posedge clk);
        irq_set <= '0;
        wait (n_dispatch == 1);
        @(posedge clk);
        irq_clr <= 5'b01000;
        @(posedge clk);
        irq_clr <= '0;

        wait (m_halted);
        repeat (12) @(posedge clk);
        pulse_flags(5'b00001);
        wait (!m_halted);
        wait (m_halted);
        repeat (12) @(posedge clk);
        press_key(8'h5A);
        wait (m_fault);
        repeat (20) @(posedge clk);

        if (u_mem.n_writes != 1) begin
            $display("ERROR: n_writes = %h, expected %h", u_mem.n_writes, 1);
            errors++;
        end
        if (n_dispatch != 1) begin
            $display("ERROR: n_dispatch = %h, expected %h", n_dispatch, 1);
            errors++;
        end
        if (n_sleeps != 2) begin
            $display("ERROR: n_sleeps = %h, expected %h", n_sleeps, 2);
            errors++;
        end
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout, the program did not finish within %0d cycles", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/10ps

module tb_memory (
    input  logic           clk,
    input  logic           rd,
    input  logic           wr,
    input  cpu_pkg::addr_t a,
    input  cpu_pkg::byte_t dout,
    output cpu_pkg::byte_t din
);
    import cpu_pkg::*;

    byte_t mem [0:65535];
    int    n_writes;

    // Background pattern under the program bytes
    initial begin
        addr_t i;
        din      = '0;
        n_writes = 0;
        for (int k = 0; k < 65536; k++) begin
            i      = addr_t'(k);
            mem[k] = i[15:8] ^ i[7:0] ^ 8'hA5;
        end
    end

    // Read data one clock after rd rises
    always @(posedge clk) begin
        if (rd)
            din <= mem[a];
        if (wr) begin
            mem[a]   <= dout;
            n_writes <= n_writes + 1;
        end
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/bus_sequencer.sv
hdl/decoder.sv
hdl/execute.sv
hdl/interrupt_unit.sv
hdl/cpu_top.sv
tests/tb_memory.sv
tests/tb_cpu.sv
